//--- hw/fpu_mul_pkg.sv
// single-precision multiply unit format widths and constants
package fpu_mul_pkg;

  ////////////////////////////////////////////////////////////
  // operand format
  ////////////////////////////////////////////////////////////

  // fraction with the hidden bit shown
  parameter int unsigned FRACT_W = 24;
  // biased exponent, wraps modulo 1024
  parameter int unsigned EXP_W = 10;
  // leading-zero count and right-shift amount
  parameter int unsigned NLZ_W = 5;

  ////////////////////////////////////////////////////////////
  // multiplier geometry
  ////////////////////////////////////////////////////////////

  // half of a padded multiplier operand
  parameter int unsigned HALF_W = 16;
  // fraction followed by 8 zero bits
  parameter int unsigned MUL_W = 32;
  // summed fraction product
  parameter int unsigned PROD_W = 48;
  // 27 product bits plus sticky
  parameter int unsigned OUT_W = 28;

  ////////////////////////////////////////////////////////////
  // exponent handling
  ////////////////////////////////////////////////////////////

  parameter logic [EXP_W-1:0] EXP_BIAS = 10'd127;
  // right shift saturates here
  parameter logic [NLZ_W-1:0] SHR_MAX = 5'd31;

endpackage

//--- hw/fpu_mul_ctrl.sv
// multiply pipeline control, tracks valid products per stage and drives ready
module fpu_mul_ctrl (
  input  logic clk,
  input  logic rst,
  // drop everything in flight
  input  logic flush_i,
  // advance pipe, stall when low
  input  logic adv_i,
  // new operation at the head
  input  logic start_i,
  output logic rdy_o
);

  // one valid bit per datapath stage
  logic s0_vld;
  logic s1_vld;
  logic s2_vld;

  // flush wins over advance
  always_ff @(posedge clk) begin
    if (rst) begin
      s0_vld <= 1'b0;
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
      rdy_o  <= 1'b0;
    end else if (flush_i) begin
      s0_vld <= 1'b0;
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
      rdy_o  <= 1'b0;
    end else if (adv_i) begin
      // start enters at stage 0
      s0_vld <= start_i;
      s1_vld <= s0_vld;
      s2_vld <= s1_vld;
      // product sits in the output regs
      rdy_o  <= s2_vld;
    end
  end

endmodule

//--- hw/fpu_mul_prenorm.sv
// multiply pre-normalization, exceptions, leading zeros and exponent sum
module fpu_mul_prenorm (
  input  logic                            clk,
  input  logic                            adv_i,
  // operand a
  input  logic                            signa_i,
  input  logic [fpu_mul_pkg::EXP_W-1:0]   exp10a_i,
  input  logic [fpu_mul_pkg::FRACT_W-1:0] fract24a_i,
  input  logic                            infa_i,
  input  logic                            zeroa_i,
  // operand b
  input  logic                            signb_i,
  input  logic [fpu_mul_pkg::EXP_W-1:0]   exp10b_i,
  input  logic [fpu_mul_pkg::FRACT_W-1:0] fract24b_i,
  input  logic                            infb_i,
  input  logic                            zerob_i,
  // nan info, just passed on
  input  logic                            snan_i,
  input  logic                            qnan_i,
  input  logic                            anan_sign_i,
  // stage 1 results
  output logic [fpu_mul_pkg::FRACT_W-1:0] s1_fract_a_o,
  output logic [fpu_mul_pkg::FRACT_W-1:0] s1_fract_b_o,
  output logic [fpu_mul_pkg::EXP_W-1:0]   s1_exp_o,
  output logic                            s1_opc_0_o,
  output logic                            s1_sign_o,
  output logic                            s1_inv_o,
  output logic                            s1_inf_o,
  output logic                            s1_snan_o,
  output logic                            s1_qnan_o,
  output logic                            s1_anan_sign_o
);

  // priority count, all zero gives 0
  function automatic logic [fpu_mul_pkg::NLZ_W-1:0] nlz(
    input logic [fpu_mul_pkg::FRACT_W-1:0] f
  );
    logic [fpu_mul_pkg::NLZ_W-1:0] cnt;
    cnt = '0;
    // highest set bit overwrites the rest
    for (int i = 0; i < fpu_mul_pkg::FRACT_W; i++) begin
      if (f[i]) cnt = fpu_mul_pkg::NLZ_W'(fpu_mul_pkg::FRACT_W - 1 - i);
    end
    return cnt;
  endfunction

  ////////////////////////////////////////////////////////////
  // stage 0
  ////////////////////////////////////////////////////////////

  logic                            s0_inv, s0_inf, s0_opc_0, s0_sign;
  logic                            s0_snan, s0_qnan, s0_anan_sign;
  logic [fpu_mul_pkg::EXP_W-1:0]   s0_exp_a, s0_exp_b;
  logic [fpu_mul_pkg::FRACT_W-1:0] s0_fract_a, s0_fract_b;
  logic [fpu_mul_pkg::NLZ_W-1:0]   s0_nlz_a, s0_nlz_b;

  always_ff @(posedge clk) begin
    if (adv_i) begin
      // 0 * inf is invalid
      s0_inv       <= (zeroa_i & infb_i) | (zerob_i & infa_i);
      s0_inf       <= infa_i | infb_i;
      s0_opc_0     <= zeroa_i | zerob_i;
      s0_sign      <= signa_i ^ signb_i;
      s0_snan      <= snan_i;
      s0_qnan      <= qnan_i;
      s0_anan_sign <= anan_sign_i;
      s0_exp_a     <= exp10a_i;
      s0_exp_b     <= exp10b_i;
      s0_fract_a   <= fract24a_i;
      s0_fract_b   <= fract24b_i;
      s0_nlz_a     <= nlz(fract24a_i);
      s0_nlz_b     <= nlz(fract24b_i);
    end
  end

  ////////////////////////////////////////////////////////////
  // stage 1
  ////////////////////////////////////////////////////////////

  // normalize denormals
  logic [fpu_mul_pkg::FRACT_W-1:0] s1t_fract_a, s1t_fract_b;
  logic [fpu_mul_pkg::EXP_W-1:0]   s1t_exp;

  assign s1t_fract_a = s0_fract_a << s0_nlz_a;
  assign s1t_fract_b = s0_fract_b << s0_nlz_b;

  // ea - nlza + eb - nlzb - bias, wraps
  assign s1t_exp = s0_exp_a - {{(fpu_mul_pkg::EXP_W-fpu_mul_pkg::NLZ_W){1'b0}}, s0_nlz_a}
                 + s0_exp_b - {{(fpu_mul_pkg::EXP_W-fpu_mul_pkg::NLZ_W){1'b0}}, s0_nlz_b}
                 - fpu_mul_pkg::EXP_BIAS;

  always_ff @(posedge clk) begin
    if (adv_i) begin
      // zero operand forces zero fraction and exponent
      s1_fract_a_o   <= s1t_fract_a & {fpu_mul_pkg::FRACT_W{~s0_opc_0}};
      s1_fract_b_o   <= s1t_fract_b & {fpu_mul_pkg::FRACT_W{~s0_opc_0}};
      s1_exp_o       <= s1t_exp & {fpu_mul_pkg::EXP_W{~s0_opc_0}};
      s1_opc_0_o     <= s0_opc_0;
      s1_sign_o      <= s0_sign;
      s1_inv_o       <= s0_inv;
      s1_inf_o       <= s0_inf;
      s1_snan_o      <= s0_snan;
      s1_qnan_o      <= s0_qnan;
      s1_anan_sign_o <= s0_anan_sign;
    end
  end

endmodule

//--- hw/fpu_mul_partial.sv
// first multiplier stage, four registered 16x16 partial products
module fpu_mul_partial (
  input  logic                              clk,
  input  logic                              adv_i,
  input  logic [fpu_mul_pkg::FRACT_W-1:0]   s1_fract_a_i,
  input  logic [fpu_mul_pkg::FRACT_W-1:0]   s1_fract_b_i,
  // lo/hi half products
  output logic [2*fpu_mul_pkg::HALF_W-1:0]  pp_albl_o,
  output logic [2*fpu_mul_pkg::HALF_W-1:0]  pp_albh_o,
  output logic [2*fpu_mul_pkg::HALF_W-1:0]  pp_ahbl_o,
  output logic [2*fpu_mul_pkg::HALF_W-1:0]  pp_ahbh_o
);

  // fractions padded with 8 zero bits
  logic [fpu_mul_pkg::MUL_W-1:0]  mul_a, mul_b;
  logic [fpu_mul_pkg::HALF_W-1:0] a_lo, a_hi, b_lo, b_hi;

  assign mul_a = {s1_fract_a_i, {(fpu_mul_pkg::MUL_W-fpu_mul_pkg::FRACT_W){1'b0}}};
  assign mul_b = {s1_fract_b_i, {(fpu_mul_pkg::MUL_W-fpu_mul_pkg::FRACT_W){1'b0}}};

  // operand halves
  assign a_lo = mul_a[fpu_mul_pkg::HALF_W-1:0];
  assign a_hi = mul_a[fpu_mul_pkg::MUL_W-1:fpu_mul_pkg::HALF_W];
  assign b_lo = mul_b[fpu_mul_pkg::HALF_W-1:0];
  assign b_hi = mul_b[fpu_mul_pkg::MUL_W-1:fpu_mul_pkg::HALF_W];

  // products widen to the 32-bit target
  always_ff @(posedge clk) begin
    if (adv_i) begin
      pp_albl_o <= a_lo * b_lo;
      pp_albh_o <= a_lo * b_hi;
      pp_ahbl_o <= a_hi * b_lo;
      pp_ahbh_o <= a_hi * b_hi;
    end
  end

endmodule

//--- hw/fpu_mul_exp_align.sv
// right-shift amount and align exponents, stage 2 copy of flags and sign
module fpu_mul_exp_align (
  input  logic                          clk,
  input  logic                          adv_i,
  input  logic [fpu_mul_pkg::EXP_W-1:0] s1_exp_i,
  input  logic                          s1_opc_0_i,
  input  logic                          s1_sign_i,
  input  logic                          s1_inv_i,
  input  logic                          s1_inf_i,
  input  logic                          s1_snan_i,
  input  logic                          s1_qnan_i,
  input  logic                          s1_anan_sign_i,
  output logic [fpu_mul_pkg::NLZ_W-1:0] s2_shr_o,
  output logic [fpu_mul_pkg::EXP_W-1:0] s2_exp10rx_o,
  output logic [fpu_mul_pkg::EXP_W-1:0] s2_exp10c_o,
  output logic                          s2_sign_o,
  output logic                          s2_inv_o,
  output logic                          s2_inf_o,
  output logic                          s2_snan_o,
  output logic                          s2_qnan_o,
  output logic                          s2_anan_sign_o
);

  logic                          exp_zero;
  logic [fpu_mul_pkg::EXP_W-1:0] shr_neg;
  logic [fpu_mul_pkg::NLZ_W-1:0] shr_t;
  logic [fpu_mul_pkg::EXP_W-1:0] exp_rx_t;

  assign exp_zero = ~(|s1_exp_i);
  // 1024 - exp + 1, wraps to 10 bits
  assign shr_neg  = 10'd1 - s1_exp_i;

  always_comb begin
    if (s1_opc_0_i) begin
      // zero product, nothing to align
      shr_t    = '0;
      exp_rx_t = '0;
    end else if (s1_exp_i[fpu_mul_pkg::EXP_W-1]) begin
      // negative sum, shift into denormal range
      shr_t    = (|shr_neg[fpu_mul_pkg::EXP_W-1:fpu_mul_pkg::NLZ_W]) ?
                 fpu_mul_pkg::SHR_MAX : shr_neg[fpu_mul_pkg::NLZ_W-1:0];
      exp_rx_t = {{(fpu_mul_pkg::EXP_W-1){1'b0}}, 1'b1};
    end else begin
      // zero sum needs one step, positive none
      shr_t    = {{(fpu_mul_pkg::NLZ_W-1){1'b0}}, exp_zero};
      exp_rx_t = s1_exp_i | {{(fpu_mul_pkg::EXP_W-1){1'b0}}, exp_zero};
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s2_shr_o       <= shr_t;
      s2_exp10rx_o   <= exp_rx_t;
      s2_exp10c_o    <= s1_exp_i;
      s2_sign_o      <= s1_sign_i;
      s2_inv_o       <= s1_inv_i;
      s2_inf_o       <= s1_inf_i;
      s2_snan_o      <= s1_snan_i;
      s2_qnan_o      <= s1_qnan_i;
      s2_anan_sign_o <= s1_anan_sign_i;
    end
  end

endmodule

//--- hw/fpu_mul_assemble.sv
// product summation with sticky reduction into the output registers
module fpu_mul_assemble (
  input  logic                             clk,
  input  logic                             adv_i,
  input  logic [2*fpu_mul_pkg::HALF_W-1:0] pp_albl_i,
  input  logic [2*fpu_mul_pkg::HALF_W-1:0] pp_albh_i,
  input  logic [2*fpu_mul_pkg::HALF_W-1:0] pp_ahbl_i,
  input  logic [2*fpu_mul_pkg::HALF_W-1:0] pp_ahbh_i,
  input  logic [fpu_mul_pkg::NLZ_W-1:0]    s2_shr_i,
  input  logic [fpu_mul_pkg::EXP_W-1:0]    s2_exp10rx_i,
  input  logic [fpu_mul_pkg::EXP_W-1:0]    s2_exp10c_i,
  input  logic                             s2_sign_i,
  input  logic                             s2_inv_i,
  input  logic                             s2_inf_i,
  input  logic                             s2_snan_i,
  input  logic                             s2_qnan_i,
  input  logic                             s2_anan_sign_i,
  output logic                             sign_o,
  output logic [fpu_mul_pkg::NLZ_W-1:0]    shr_o,
  output logic [fpu_mul_pkg::EXP_W-1:0]    exp10shr_o,
  output logic [fpu_mul_pkg::EXP_W-1:0]    exp10sh0_o,
  output logic [fpu_mul_pkg::OUT_W-1:0]    fract28_o,
  output logic                             inv_o,
  output logic                             inf_o,
  output logic                             snan_o,
  output logic                             qnan_o,
  output logic                             anan_sign_o
);

  localparam int unsigned HW = fpu_mul_pkg::HALF_W;
  // lowest bit kept above sticky
  localparam int unsigned KEEP_LSB = fpu_mul_pkg::PROD_W - fpu_mul_pkg::OUT_W + 1;

  // 64-bit product shifted down by 16
  logic [fpu_mul_pkg::PROD_W-1:0] prod;
  logic                           sticky;

  assign prod = {pp_ahbh_i, {HW{1'b0}}}
              + {{HW{1'b0}}, pp_ahbl_i}
              + {{HW{1'b0}}, pp_albh_i}
              + {{2*HW{1'b0}}, pp_albl_i[2*HW-1:HW]};

  // or of everything below the kept bits
  assign sticky = |prod[KEEP_LSB-1:0];

  always_ff @(posedge clk) begin
    if (adv_i) begin
      sign_o      <= s2_sign_i;
      shr_o       <= s2_shr_i;
      exp10shr_o  <= s2_exp10rx_i;
      exp10sh0_o  <= s2_exp10c_i;
      fract28_o   <= {prod[fpu_mul_pkg::PROD_W-1:KEEP_LSB], sticky};
      inv_o       <= s2_inv_i;
      inf_o       <= s2_inf_i;
      snan_o      <= s2_snan_i;
      qnan_o      <= s2_qnan_i;
      anan_sign_o <= s2_anan_sign_i;
    end
  end

endmodule

//--- hw/fpu_mul_top.sv
// single-precision multiply unit top, control plus four-stage datapath
module fpu_mul_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            flush_i,
  input  logic                            adv_i,
  input  logic                            start_i,
  // operand a
  input  logic                            signa_i,
  input  logic [fpu_mul_pkg::EXP_W-1:0]   exp10a_i,
  input  logic [fpu_mul_pkg::FRACT_W-1:0] fract24a_i,
  input  logic                            infa_i,
  input  logic                            zeroa_i,
  // operand b
  input  logic                            signb_i,
  input  logic [fpu_mul_pkg::EXP_W-1:0]   exp10b_i,
  input  logic [fpu_mul_pkg::FRACT_W-1:0] fract24b_i,
  input  logic                            infb_i,
  input  logic                            zerob_i,
  input  logic                            snan_i,
  input  logic                            qnan_i,
  input  logic                            anan_sign_i,
  // to align and round
  output logic                            rdy_o,
  output logic                            sign_o,
  output logic [fpu_mul_pkg::NLZ_W-1:0]   shr_o,
  output logic [fpu_mul_pkg::EXP_W-1:0]   exp10shr_o,
  output logic [fpu_mul_pkg::EXP_W-1:0]   exp10sh0_o,
  output logic [fpu_mul_pkg::OUT_W-1:0]   fract28_o,
  output logic                            inv_o,
  output logic                            inf_o,
  output logic                            snan_o,
  output logic                            qnan_o,
  output logic                            anan_sign_o
);

  ////////////////////////////////////////////////////////////
  // interstage wires
  ////////////////////////////////////////////////////////////

  logic [fpu_mul_pkg::FRACT_W-1:0]  s1_fract_a, s1_fract_b;
  logic [fpu_mul_pkg::EXP_W-1:0]    s1_exp;
  logic                             s1_opc_0, s1_sign, s1_inv, s1_inf;
  logic                             s1_snan, s1_qnan, s1_anan_sign;
  logic [2*fpu_mul_pkg::HALF_W-1:0] pp_albl, pp_albh, pp_ahbl, pp_ahbh;
  logic [fpu_mul_pkg::NLZ_W-1:0]    s2_shr;
  logic [fpu_mul_pkg::EXP_W-1:0]    s2_exp10rx, s2_exp10c;
  logic                             s2_sign, s2_inv, s2_inf;
  logic                             s2_snan, s2_qnan, s2_anan_sign;

  fpu_mul_ctrl ctrl_i (
    .clk, .rst, .flush_i, .adv_i, .start_i, .rdy_o
  );

  // stages 0 and 1
  fpu_mul_prenorm prenorm_i (
    .clk, .adv_i,
    .signa_i, .exp10a_i, .fract24a_i, .infa_i, .zeroa_i,
    .signb_i, .exp10b_i, .fract24b_i, .infb_i, .zerob_i,
    .snan_i, .qnan_i, .anan_sign_i,
    .s1_fract_a_o(s1_fract_a), .s1_fract_b_o(s1_fract_b),
    .s1_exp_o(s1_exp), .s1_opc_0_o(s1_opc_0), .s1_sign_o(s1_sign),
    .s1_inv_o(s1_inv), .s1_inf_o(s1_inf), .s1_snan_o(s1_snan),
    .s1_qnan_o(s1_qnan), .s1_anan_sign_o(s1_anan_sign)
  );

  // stage 2, multiplier and exponent side by side
  fpu_mul_partial partial_i (
    .clk, .adv_i,
    .s1_fract_a_i(s1_fract_a), .s1_fract_b_i(s1_fract_b),
    .pp_albl_o(pp_albl), .pp_albh_o(pp_albh),
    .pp_ahbl_o(pp_ahbl), .pp_ahbh_o(pp_ahbh)
  );

  fpu_mul_exp_align exp_align_i (
    .clk, .adv_i,
    .s1_exp_i(s1_exp), .s1_opc_0_i(s1_opc_0), .s1_sign_i(s1_sign),
    .s1_inv_i(s1_inv), .s1_inf_i(s1_inf), .s1_snan_i(s1_snan),
    .s1_qnan_i(s1_qnan), .s1_anan_sign_i(s1_anan_sign),
    .s2_shr_o(s2_shr), .s2_exp10rx_o(s2_exp10rx), .s2_exp10c_o(s2_exp10c),
    .s2_sign_o(s2_sign), .s2_inv_o(s2_inv), .s2_inf_o(s2_inf),
    .s2_snan_o(s2_snan), .s2_qnan_o(s2_qnan), .s2_anan_sign_o(s2_anan_sign)
  );

  // stage 3 outputs
  fpu_mul_assemble assemble_i (
    .clk, .adv_i,
    .pp_albl_i(pp_albl), .pp_albh_i(pp_albh),
    .pp_ahbl_i(pp_ahbl), .pp_ahbh_i(pp_ahbh),
    .s2_shr_i(s2_shr), .s2_exp10rx_i(s2_exp10rx), .s2_exp10c_i(s2_exp10c),
    .s2_sign_i(s2_sign), .s2_inv_i(s2_inv), .s2_inf_i(s2_inf),
    .s2_snan_i(s2_snan), .s2_qnan_i(s2_qnan), .s2_anan_sign_i(s2_anan_sign),
    .sign_o, .shr_o, .exp10shr_o, .exp10sh0_o, .fract28_o,
    .inv_o, .inf_o, .snan_o, .qnan_o, .anan_sign_o
  );

endmodule

//--- testbench/fpu_mul_props.sv
// ready and stall assertions, bound into the multiply unit top
module fpu_mul_props (
  input logic        clk,
  input logic        rst,
  input logic        flush_i,
  input logic        adv_i,
  input logic        rdy_o,
  input logic        sign_o,
  input logic [4:0]  shr_o,
  input logic [9:0]  exp10shr_o,
  input logic [9:0]  exp10sh0_o,
  input logic [27:0] fract28_o,
  input logic        inv_o,
  input logic        inf_o,
  input logic        snan_o,
  input logic        qnan_o,
  input logic        anan_sign_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // bumped by every failing assertion
  int unsigned fail_cnt = 0;

  logic [58:0] data;

  assign data = {sign_o, shr_o, exp10shr_o, exp10sh0_o, fract28_o,
                 inv_o, inf_o, snan_o, qnan_o, anan_sign_o};

  // low through reset and the cycle after
  rdy_reset: assert property (@(posedge clk) rst |=> !rdy_o)
    else begin
      fail_cnt++;
      $error("ready high during or right after reset");
    end

  rdy_flush: assert property (@(posedge clk) disable iff (rst) flush_i |=> !rdy_o)
    else begin
      fail_cnt++;
      $error("ready high in the cycle after a flush");
    end

  // stalled edge freezes data and ready
  data_hold: assert property (@(posedge clk) disable iff (rst) !adv_i |=> $stable(data))
    else begin
      fail_cnt++;
      $error("output data changed while stalled");
    end

  rdy_hold: assert property (@(posedge clk) disable iff (rst)
                             !adv_i && !flush_i |=> $stable(rdy_o))
    else begin
      fail_cnt++;
      $error("ready changed while stalled");
    end

endmodule

bind fpu_mul_top fpu_mul_props props_i (.*);

//--- testbench/fpu_mul_checker.sv
// multiply unit scoreboard, reference model, expected queue and report
module fpu_mul_checker (
  input logic        clk,
  input logic        rst,
  input logic        flush_i,
  input logic        adv_i,
  input logic        start_i,
  input logic        signa_i,
  input logic [9:0]  exp10a_i,
  input logic [23:0] fract24a_i,
  input logic        infa_i,
  input logic        zeroa_i,
  input logic        signb_i,
  input logic [9:0]  exp10b_i,
  input logic [23:0] fract24b_i,
  input logic        infb_i,
  input logic        zerob_i,
  input logic        snan_i,
  input logic        qnan_i,
  input logic        anan_sign_i,
  // DUT outputs
  input logic        res_rdy_i,
  input logic        res_sign_i,
  input logic [4:0]  res_shr_i,
  input logic [9:0]  res_exp10shr_i,
  input logic [9:0]  res_exp10sh0_i,
  input logic [27:0] res_fract28_i,
  input logic        res_inv_i,
  input logic        res_inf_i,
  input logic        res_snan_i,
  input logic        res_qnan_i,
  input logic        res_anan_sign_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // sign, shr, exp10shr, exp10sh0, fract28, inv, inf, snan, qnan, anan_sign
  logic [58:0] exp_q[$];
  int          stamp_q[$];
  logic [58:0] act;
  logic [58:0] expv;
  logic [58:0] hold_ref;
  logic        hold_vld;
  logic        adv_d;
  int          adv_cnt = 0;
  int          lat;
  int          checks = 0;
  int          errs = 0;
  int          test_checks = 0;
  int          test_errs = 0;
  string       test_name = "reset";

  assign act = {res_sign_i, res_shr_i, res_exp10shr_i, res_exp10sh0_i, res_fract28_i,
                res_inv_i, res_inf_i, res_snan_i, res_qnan_i, res_anan_sign_i};

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // leading zeros from the top, all zero counts as 0
  function automatic logic [4:0] lead_zeros(input logic [23:0] f);
    int n;
    n = 0;
    if (f != 24'd0) begin
      while (f[23 - n] == 1'b0) begin
        n++;
      end
    end
    return 5'(n);
  endfunction

  function automatic logic [58:0] ref_mul(
    input logic        sa,
    input logic [9:0]  ea,
    input logic [23:0] fa,
    input logic        ia,
    input logic        za,
    input logic        sb,
    input logic [9:0]  eb,
    input logic [23:0] fb,
    input logic        ib,
    input logic        zb,
    input logic        sn,
    input logic        qn,
    input logic        an
  );
    logic [4:0]  na;
    logic [4:0]  nb;
    logic [23:0] ma;
    logic [23:0] mb;
    logic [9:0]  e;
    logic [47:0] q;
    logic [4:0]  shr;
    logic [9:0]  erx;
    int          d;
    if (za || zb) begin
      // zero product, nothing to align
      ma  = '0;
      mb  = '0;
      e   = '0;
      shr = '0;
      erx = '0;
    end else begin
      na = lead_zeros(fa);
      nb = lead_zeros(fb);
      ma = fa << na;
      mb = fb << nb;
      // both counts off the biased sum, 10-bit wrap
      e = ea + eb - 10'(na) - 10'(nb) - 10'd127;
      if (e[9]) begin
        // distance below exponent 1
        d   = (1025 - int'(e)) % 1024;
        shr = (d > 31) ? 5'd31 : 5'(d);
        erx = 10'd1;
      end else begin
        shr = (e == 10'd0) ? 5'd1 : 5'd0;
        erx = (e == 10'd0) ? 10'd1 : e;
      end
    end
    q = {24'd0, ma} * {24'd0, mb};
    return {sa ^ sb, shr, erx, e, q[47:21], |q[20:0],
            (za & ib) | (zb & ia), ia | ib, sn, qn, an};
  endfunction

  ////////////////////////////////////////////////////////////
  // bookkeeping
  ////////////////////////////////////////////////////////////

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic note_error();
    errs++;
    test_errs++;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errs   = 0;
  endtask

  task automatic end_test();
    $display("test %s done, %0d results checked, %0d errors", test_name, test_checks,
             test_errs);
  endtask

  task automatic report(input int timeouts, input int prop_fails);
    $display("checks %0d errors %0d timeouts %0d assertion failures %0d", checks, errs,
             timeouts, prop_fails);
  endtask

  ////////////////////////////////////////////////////////////
  // compare process
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      exp_q.delete();
      stamp_q.delete();
      adv_d    = 1'b0;
      hold_vld = 1'b0;
    end else begin
      // result loaded by the previous advancing edge
      if (adv_d && res_rdy_i) begin
        if (exp_q.size() == 0) begin
          $display("result came out with no operation in flight in %s", test_name);
          note_error();
        end else begin
          expv = exp_q.pop_front();
          lat  = adv_cnt - stamp_q.pop_front();
          checks++;
          test_checks++;
          if (act !== expv) begin
            $display("FAILED %s expected %h actual %h", test_name, expv, act);
            note_error();
          end
          if (lat != 4) begin
            $display("FAILED %s latency expected 4 actual %0d", test_name, lat);
            note_error();
          end
        end
      end
      // a stalled edge leaves the outputs alone
      if (hold_vld && !adv_d && act !== hold_ref) begin
        $display("outputs changed during a stall in %s", test_name);
        note_error();
      end
      hold_ref = act;
      hold_vld = 1'b1;
      if (flush_i) begin
        exp_q.delete();
        stamp_q.delete();
      end else if (adv_i && start_i) begin
        exp_q.push_back(ref_mul(signa_i, exp10a_i, fract24a_i, infa_i, zeroa_i,
                                signb_i, exp10b_i, fract24b_i, infb_i, zerob_i,
                                snan_i, qnan_i, anan_sign_i));
        stamp_q.push_back(adv_cnt);
      end
      if (adv_i) begin
        adv_cnt++;
      end
      adv_d = adv_i;
    end
  end

endmodule

//--- testbench/tb_fpu_mul.sv
// multiply unit testbench, clock, reset, stimulus and the test sequence
module tb_fpu_mul;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        rst;
  logic        flush_i;
  logic        adv_i;
  logic        start_i;
  logic        signa_i;
  logic [9:0]  exp10a_i;
  logic [23:0] fract24a_i;
  logic        infa_i;
  logic        zeroa_i;
  logic        signb_i;
  logic [9:0]  exp10b_i;
  logic [23:0] fract24b_i;
  logic        infb_i;
  logic        zerob_i;
  logic        snan_i;
  logic        qnan_i;
  logic        anan_sign_i;
  logic        rdy_o;
  logic        sign_o;
  logic [4:0]  shr_o;
  logic [9:0]  exp10shr_o;
  logic [9:0]  exp10sh0_o;
  logic [27:0] fract28_o;
  logic        inv_o;
  logic        inf_o;
  logic        snan_o;
  logic        qnan_o;
  logic        anan_sign_o;
  int          timeouts;

  fpu_mul_top fpu_mul_top_i (.*);

  // scoreboard sees the same pins as the DUT
  fpu_mul_checker checker_i (
    .*,
    .res_rdy_i(rdy_o),
    .res_sign_i(sign_o),
    .res_shr_i(shr_o),
    .res_exp10shr_i(exp10shr_o),
    .res_exp10sh0_i(exp10sh0_o),
    .res_fract28_i(fract28_o),
    .res_inv_i(inv_o),
    .res_inf_i(inf_o),
    .res_snan_i(snan_o),
    .res_qnan_i(qnan_o),
    .res_anan_sign_i(anan_sign_o)
  );

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  // inputs change just after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [23:0] rand_frac();
    return {1'b1, 23'($urandom)};
  endfunction

  // keeps the product exponent in the normal range
  function automatic logic [9:0] rand_exp();
    return 10'(100 + $urandom % 60);
  endfunction

  // plain finite operands, random signs
  task automatic put_op(input logic [9:0] ea, input logic [23:0] fa,
                        input logic [9:0] eb, input logic [23:0] fb);
    start_i     = 1'b1;
    signa_i     = 1'($urandom);
    signb_i     = 1'($urandom);
    exp10a_i    = ea;
    fract24a_i  = fa;
    exp10b_i    = eb;
    fract24b_i  = fb;
    infa_i      = 1'b0;
    zeroa_i     = 1'b0;
    infb_i      = 1'b0;
    zerob_i     = 1'b0;
    snan_i      = 1'b0;
    qnan_i      = 1'b0;
    anan_sign_i = 1'b0;
  endtask

  // run idle until every accepted operation has come out
  task automatic drain();
    int n;
    n = 0;
    start_i = 1'b0;
    adv_i   = 1'b1;
    while (checker_i.pending() != 0 && n < 40) begin
      step();
      n++;
    end
    if (checker_i.pending() != 0) begin
      $display("timeout waiting for ready");
      timeouts++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(2805));
    timeouts = 0;
    rst      = 1'b1;
    flush_i  = 1'b0;
    adv_i    = 1'b0;
    put_op(10'd0, 24'd0, 10'd0, 24'd0);
    start_i  = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst   = 1'b0;
    adv_i = 1'b1;

    // back to back, one per cycle
    checker_i.begin_test("normal");
    repeat (40) begin
      put_op(rand_exp(), rand_frac(), rand_exp(), rand_frac());
      step();
    end
    drain();
    checker_i.end_test();

    // sums at or below zero
    checker_i.begin_test("small_exp");
    put_op(10'd60, rand_frac(), 10'd67, rand_frac());
    step();
    repeat (30) begin
      put_op(10'(1 + $urandom % 70), rand_frac(), 10'(1 + $urandom % 70), rand_frac());
      step();
    end
    drain();
    checker_i.end_test();

    // leading zeros on a, a few on b
    checker_i.begin_test("denormal");
    repeat (30) begin
      put_op(10'd1, rand_frac() >> ($urandom % 24), rand_exp(), rand_frac() >> ($urandom % 3));
      step();
    end
    drain();
    checker_i.end_test();

    // each operand normal, zero or infinity
    checker_i.begin_test("special");
    for (int i = 0; i < 9; i++) begin
      repeat (3) begin
        put_op(rand_exp(), rand_frac(), rand_exp(), rand_frac());
        zeroa_i     = (i % 3) == 1;
        infa_i      = (i % 3) == 2;
        zerob_i     = (i / 3) == 1;
        infb_i      = (i / 3) == 2;
        snan_i      = 1'($urandom);
        qnan_i      = 1'($urandom);
        anan_sign_i = 1'($urandom);
        step();
      end
    end
    drain();
    checker_i.end_test();

    // about one edge in three stalls
    checker_i.begin_test("stall");
    repeat (60) begin
      put_op(rand_exp(), rand_frac(), rand_exp(), rand_frac());
      start_i = 1'($urandom);
      adv_i   = ($urandom % 3) != 0;
      step();
    end
    drain();
    checker_i.end_test();

    // second round flushes during a stall
    checker_i.begin_test("flush");
    for (int k = 0; k < 2; k++) begin
      repeat (3) begin
        put_op(rand_exp(), rand_frac(), rand_exp(), rand_frac());
        step();
      end
      start_i = 1'b0;
      adv_i   = (k == 0);
      flush_i = 1'b1;
      step();
      flush_i = 1'b0;
      adv_i   = 1'b1;
      // nothing may come out here
      repeat (6) step();
    end
    put_op(rand_exp(), rand_frac(), rand_exp(), rand_frac());
    step();
    drain();
    checker_i.end_test();

    checker_i.report(timeouts, fpu_mul_top_i.props_i.fail_cnt);
    if (checker_i.errs == 0 && checker_i.checks > 0 && timeouts == 0 &&
        fpu_mul_top_i.props_i.fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- files.f
hw/fpu_mul_pkg.sv
hw/fpu_mul_ctrl.sv
hw/fpu_mul_prenorm.sv
hw/fpu_mul_partial.sv
hw/fpu_mul_exp_align.sv
hw/fpu_mul_assemble.sv
hw/fpu_mul_top.sv
testbench/fpu_mul_props.sv
testbench/fpu_mul_checker.sv
testbench/tb_fpu_mul.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
TOP        = tb_fpu_mul
FILELIST   = files.f
RTL_TOP    = fpu_mul_top
LINT_FLAGS = --lint-only -Wall --timing --assert --timescale 1ns/1ps
RUN_ARGS   = +verilator+error+limit+100
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS)); echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
